/* include/wb_params.svh */
`ifndef WB_PARAMS_SVH
`define WB_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// datapath widths of the writeback path.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// operand and result width.
`define WB_DW 32

// physical register tag width.
`define WB_TAG_W 6

// reorder buffer entry id width.
`define WB_ID_W 4

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// writeback arbitration.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// units competing for the single rob write port, alu is way 0.
`define WB_WAYS 2

`endif

/* verilog/wb_pkg.sv */
package wb_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // integer unit opcodes.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   typedef enum logic [2:0]
   {
      ALU_ADD = 3'd0,   // a + b.
      ALU_SUB = 3'd1,   // a - b.
      ALU_AND = 3'd2,   // bitwise and.
      ALU_OR  = 3'd3,   // bitwise or.
      ALU_XOR = 3'd4,   // bitwise xor.
      ALU_SLL = 3'd5,   // logical left shift by b[4:0].
      ALU_SRL = 3'd6    // logical right shift by b[4:0].
   } alu_op_e;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // multiplier sequencing.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   typedef enum logic [1:0]
   {
      MUL_IDLE = 2'd0,  // ready for a new operation.
      MUL_BUSY = 2'd1,  // shift-add steps in progress.
      MUL_DONE = 2'd2   // product waiting for writeback.
   } mul_state_e;

endpackage

/* verilog/wb_arbiter.sv */
`include "wb_params.svh"

module wb_arbiter
#(
   parameter int WAYS = 2
)
(
   input  logic                         clk,            // only sampled by bound checks.
   input  logic                         arst_n,
   input  logic [WAYS-1:0]              fu_wb_valid,
   output logic [WAYS-1:0]              fu_wb_ready,
   input  logic [WAYS*`WB_DW-1:0]       fu_wb_data,
   input  logic [WAYS*`WB_TAG_W-1:0]    fu_wb_tag,
   input  logic [WAYS*`WB_ID_W-1:0]     fu_wb_id,
   output logic                         rob_wb_valid,
   input  logic                         rob_wb_ready,
   output logic [`WB_DW-1:0]            rob_wb_data,
   output logic [`WB_TAG_W-1:0]         rob_wb_tag,
   output logic [`WB_ID_W-1:0]          rob_wb_id
);

   logic [WAYS-1:0] grant;   // one-hot, or zero when nobody is valid.

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // fixed priority, lowest way wins.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // two's complement trick keeps only the lowest set bit.
   assign grant = fu_wb_valid & (~fu_wb_valid + 1'b1);

   // only the winner sees the rob handshake.
   assign fu_wb_ready = grant & {WAYS{rob_wb_ready}};

   assign rob_wb_valid = |fu_wb_valid;   // any unit pending.

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // and-or result mux.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_comb
   begin
      rob_wb_data = '0;   // zero when no way is granted.
      rob_wb_tag  = '0;
      rob_wb_id   = '0;

      for (int i = 0; i < WAYS; i++)
      begin
         // at most one grant bit is set, so or-ing is a clean select.
         rob_wb_data = rob_wb_data |
                       (fu_wb_data[i*`WB_DW +: `WB_DW] & {`WB_DW{grant[i]}});
         rob_wb_tag  = rob_wb_tag |
                       (fu_wb_tag[i*`WB_TAG_W +: `WB_TAG_W] & {`WB_TAG_W{grant[i]}});
         rob_wb_id   = rob_wb_id |
                       (fu_wb_id[i*`WB_ID_W +: `WB_ID_W] & {`WB_ID_W{grant[i]}});
      end
   end

endmodule

/* verilog/alu_unit.sv */
`include "wb_params.svh"

module alu_unit
(
   input  logic                  clk,
   input  logic                  arst_n,
   // issue side.
   input  logic                  issue_valid,
   output logic                  issue_ready,
   input  wb_pkg::alu_op_e       op,
   input  logic [`WB_DW-1:0]     a,
   input  logic [`WB_DW-1:0]     b,
   input  logic [`WB_TAG_W-1:0]  tag,
   input  logic [`WB_ID_W-1:0]   id,
   // writeback side.
   output logic                  wb_valid,
   input  logic                  wb_ready,
   output logic [`WB_DW-1:0]     wb_data,
   output logic [`WB_TAG_W-1:0]  wb_tag,
   output logic [`WB_ID_W-1:0]   wb_id
);

   import wb_pkg::*;

   localparam int SH_W = $clog2(`WB_DW);   // shift amount bits, 5 for 32.

   logic [`WB_DW-1:0] result;      // combinational alu output.
   logic [SH_W-1:0]   shamt;
   logic              issue_fire;  // operation accepted this cycle.

   assign shamt = b[SH_W-1:0];

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // execute.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_comb
   begin
      case (op)
         ALU_ADD: result = a + b;
         ALU_SUB: result = a - b;
         ALU_AND: result = a & b;
         ALU_OR:  result = a | b;
         ALU_XOR: result = a ^ b;
         ALU_SLL: result = a << shamt;
         ALU_SRL: result = a >> shamt;
         default: result = '0;   // unused encoding.
      endcase
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // one-entry result holding register.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // free slot, or the held result leaves on this same edge.
   assign issue_ready = !wb_valid || wb_ready;
   assign issue_fire  = issue_valid && issue_ready;

   // valid bit.
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wb_valid <= 1'b0;
      end
      else if (issue_fire)
      begin
         wb_valid <= 1'b1;   // refill, possibly while draining.
      end
      else if (wb_ready)
      begin
         wb_valid <= 1'b0;   // drained, nothing behind it.
      end
   end

   // payload, only written on acceptance so it holds under back-pressure.
   always_ff @(posedge clk)
   begin
      if (issue_fire)
      begin
         wb_data <= result;
         wb_tag  <= tag;
         wb_id   <= id;
      end
   end

endmodule

/* verilog/mul_unit.sv */
`include "wb_params.svh"

module mul_unit
(
   input  logic                  clk,
   input  logic                  arst_n,
   // issue side.
   input  logic                  issue_valid,
   output logic                  issue_ready,
   input  logic [`WB_DW-1:0]     a,
   input  logic [`WB_DW-1:0]     b,
   input  logic [`WB_TAG_W-1:0]  tag,
   input  logic [`WB_ID_W-1:0]   id,
   // writeback side.
   output logic                  wb_valid,
   input  logic                  wb_ready,
   output logic [`WB_DW-1:0]     wb_data,
   output logic [`WB_TAG_W-1:0]  wb_tag,
   output logic [`WB_ID_W-1:0]   wb_id
);

   import wb_pkg::*;

   localparam int CNT_W = $clog2(`WB_DW);   // enough for WB_DW steps.

   mul_state_e        state;
   logic [CNT_W-1:0]  bit_cnt;     // multiplier bits consumed so far.
   logic [`WB_DW-1:0] mcand;       // shifted left each step.
   logic [`WB_DW-1:0] mplier;      // shifted right each step.
   logic [`WB_DW-1:0] acc;         // running low product.
   logic              issue_fire;
   logic              last_step;

   assign issue_ready = (state == MUL_IDLE);   // one operation in flight.
   assign issue_fire  = issue_valid && issue_ready;
   assign last_step   = (bit_cnt == CNT_W'(`WB_DW - 1));

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // control FSM.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state   <= MUL_IDLE;
         bit_cnt <= '0;
      end
      else
      begin
         case (state)
            MUL_IDLE:
            begin
               if (issue_fire)
               begin
                  state   <= MUL_BUSY;
                  bit_cnt <= '0;
               end
            end
            MUL_BUSY:
            begin
               bit_cnt <= bit_cnt + 1'b1;
               // WB_DW busy cycles, then present the product.
               if (last_step)
               begin
                  state <= MUL_DONE;
               end
            end
            MUL_DONE:
            begin
               if (wb_ready)
               begin
                  state <= MUL_IDLE;   // handed to the rob.
               end
            end
            default: state <= MUL_IDLE;
         endcase
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // shift-add datapath.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk)
   begin
      if (issue_fire)
      begin
         mcand  <= a;
         mplier <= b;
         acc    <= '0;
         wb_tag <= tag;   // carried alongside until writeback.
         wb_id  <= id;
      end
      else if (state == MUL_BUSY)
      begin
         if (mplier[0])
         begin
            acc <= acc + mcand;   // add the weighted multiplicand.
         end
         mcand  <= mcand << 1;    // upper bits fall off, low product only.
         mplier <= mplier >> 1;
      end
   end

   // acc is untouched in MUL_DONE so the result holds under back-pressure.
   assign wb_valid = (state == MUL_DONE);
   assign wb_data  = acc;

endmodule

/* verilog/wb_subsys_top.sv */
`include "wb_params.svh"

module wb_subsys_top
(
   input  logic                  clk,
   input  logic                  arst_n,
   // alu issue port.
   input  logic                  alu_issue_valid,
   output logic                  alu_issue_ready,
   input  wb_pkg::alu_op_e       alu_op,
   input  logic [`WB_DW-1:0]     alu_a,
   input  logic [`WB_DW-1:0]     alu_b,
   input  logic [`WB_TAG_W-1:0]  alu_tag,
   input  logic [`WB_ID_W-1:0]   alu_id,
   // multiplier issue port.
   input  logic                  mul_issue_valid,
   output logic                  mul_issue_ready,
   input  logic [`WB_DW-1:0]     mul_a,
   input  logic [`WB_DW-1:0]     mul_b,
   input  logic [`WB_TAG_W-1:0]  mul_tag,
   input  logic [`WB_ID_W-1:0]   mul_id,
   // toward the reorder buffer.
   output logic                  rob_wb_valid,
   input  logic                  rob_wb_ready,
   output logic [`WB_DW-1:0]     rob_wb_data,
   output logic [`WB_TAG_W-1:0]  rob_wb_tag,
   output logic [`WB_ID_W-1:0]   rob_wb_id
);

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // packed unit writeback buses, way 0 is the alu.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   logic [`WB_WAYS-1:0]            fu_wb_valid;
   logic [`WB_WAYS-1:0]            fu_wb_ready;
   logic [`WB_WAYS*`WB_DW-1:0]     fu_wb_data;
   logic [`WB_WAYS*`WB_TAG_W-1:0]  fu_wb_tag;
   logic [`WB_WAYS*`WB_ID_W-1:0]   fu_wb_id;

   alu_unit u_alu
   (
      .clk         (clk),
      .arst_n      (arst_n),
      .issue_valid (alu_issue_valid),
      .issue_ready (alu_issue_ready),
      .op          (alu_op),
      .a           (alu_a),
      .b           (alu_b),
      .tag         (alu_tag),
      .id          (alu_id),
      .wb_valid    (fu_wb_valid[0]),
      .wb_ready    (fu_wb_ready[0]),
      .wb_data     (fu_wb_data[0*`WB_DW +: `WB_DW]),
      .wb_tag      (fu_wb_tag[0*`WB_TAG_W +: `WB_TAG_W]),
      .wb_id       (fu_wb_id[0*`WB_ID_W +: `WB_ID_W])
   );

   mul_unit u_mul
   (
      .clk         (clk),
      .arst_n      (arst_n),
      .issue_valid (mul_issue_valid),
      .issue_ready (mul_issue_ready),
      .a           (mul_a),
      .b           (mul_b),
      .tag         (mul_tag),
      .id          (mul_id),
      .wb_valid    (fu_wb_valid[1]),
      .wb_ready    (fu_wb_ready[1]),
      .wb_data     (fu_wb_data[1*`WB_DW +: `WB_DW]),
      .wb_tag      (fu_wb_tag[1*`WB_TAG_W +: `WB_TAG_W]),
      .wb_id       (fu_wb_id[1*`WB_ID_W +: `WB_ID_W])
   );

   // combinational, adds no cycle between unit and rob.
   wb_arbiter #(.WAYS(`WB_WAYS)) u_arb
   (
      .clk          (clk),
      .arst_n       (arst_n),
      .fu_wb_valid  (fu_wb_valid),
      .fu_wb_ready  (fu_wb_ready),
      .fu_wb_data   (fu_wb_data),
      .fu_wb_tag    (fu_wb_tag),
      .fu_wb_id     (fu_wb_id),
      .rob_wb_valid (rob_wb_valid),
      .rob_wb_ready (rob_wb_ready),
      .rob_wb_data  (rob_wb_data),
      .rob_wb_tag   (rob_wb_tag),
      .rob_wb_id    (rob_wb_id)
   );

endmodule

/* verif/tb_clkgen.sv */
module tb_clkgen
#(
   parameter int PERIOD = 8   // clock period in time units.
)
(
   output logic clk
);

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #(PERIOD / 2) clk = ~clk;   // even duty cycle.
      end
   end

endmodule

/* verif/wb_assertions.sv */
`include "wb_params.svh"

module wb_assertions
#(
   parameter int WAYS = 2
)
(
   input logic                  clk,
   input logic                  arst_n,
   input logic [WAYS-1:0]       fu_wb_valid,
   input logic [WAYS-1:0]       grant,          // arbiter internal one-hot.
   input logic                  rob_wb_valid,
   input logic                  rob_wb_ready,
   input logic [`WB_DW-1:0]     rob_wb_data,
   input logic [`WB_TAG_W-1:0]  rob_wb_tag,
   input logic [`WB_ID_W-1:0]   rob_wb_id
);

   int unsigned fail_count;   // failed assertion attempts so far.

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // grant shape.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   a_grant_onehot: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(grant))
      else
      begin
         $error("writeback grant has more than one bit set.");
         fail_count++;
      end

   // nothing valid below the granted way.
   a_grant_lowest: assert property (@(posedge clk) disable iff (!arst_n)
      ((grant - 1'b1) & fu_wb_valid & {WAYS{|grant}}) == '0)
      else
      begin
         $error("a lower way is valid but was not granted.");
         fail_count++;
      end

   a_valid_grant: assert property (@(posedge clk) disable iff (!arst_n)
      rob_wb_valid == (|grant))
      else
      begin
         $error("rob_wb_valid does not match the grant.");
         fail_count++;
      end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // back-pressure.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   a_stall_valid: assert property (@(posedge clk) disable iff (!arst_n)
      rob_wb_valid && !rob_wb_ready |=> rob_wb_valid)
      else
      begin
         $error("rob_wb_valid dropped while the rob stalled.");
         fail_count++;
      end

   // only a higher-priority way may take over during a stall and otherwise the payload holds.
   a_stall_hold: assert property (@(posedge clk) disable iff (!arst_n)
      rob_wb_valid && !rob_wb_ready |=> (grant < $past(grant)) ||
      ($stable(rob_wb_data) && $stable(rob_wb_tag) && $stable(rob_wb_id)))
      else
      begin
         $error("rob writeback payload changed while the rob stalled.");
         fail_count++;
      end

endmodule

bind wb_arbiter wb_assertions #(.WAYS(WAYS)) u_wb_assertions
(
   .clk          (clk),
   .arst_n       (arst_n),
   .fu_wb_valid  (fu_wb_valid),
   .grant        (grant),
   .rob_wb_valid (rob_wb_valid),
   .rob_wb_ready (rob_wb_ready),
   .rob_wb_data  (rob_wb_data),
   .rob_wb_tag   (rob_wb_tag),
   .rob_wb_id    (rob_wb_id)
);

/* verif/wb_tb.sv */
`include "wb_params.svh"

module wb_tb;

   import wb_pkg::*;

   localparam int T_ISSUE = 200;    // cycles an issue or id may stall.
   localparam int T_DRAIN = 2000;   // cycles to empty the whole path.
   localparam int NIDS    = 1 << `WB_ID_W;

   logic                  clk;
   logic                  arst_n;
   logic                  alu_issue_valid;
   logic                  alu_issue_ready;
   alu_op_e               alu_op;
   logic [`WB_DW-1:0]     alu_a;
   logic [`WB_DW-1:0]     alu_b;
   logic [`WB_TAG_W-1:0]  alu_tag;
   logic [`WB_ID_W-1:0]   alu_id;
   logic                  mul_issue_valid;
   logic                  mul_issue_ready;
   logic [`WB_DW-1:0]     mul_a;
   logic [`WB_DW-1:0]     mul_b;
   logic [`WB_TAG_W-1:0]  mul_tag;
   logic [`WB_ID_W-1:0]   mul_id;
   logic                  rob_wb_valid;
   logic                  rob_wb_ready;
   logic [`WB_DW-1:0]     rob_wb_data;
   logic [`WB_TAG_W-1:0]  rob_wb_tag;
   logic [`WB_ID_W-1:0]   rob_wb_id;

   integer                seed;
   int unsigned           cycle;           // posedge count.
   int unsigned           issued;
   int unsigned           written;
   int unsigned           errors;
   bit                    streams_done;
   logic [`WB_ID_W-1:0]   next_id;
   bit                    pending [NIDS];  // issued and not yet written back.
   logic [`WB_DW-1:0]     exp_data [NIDS];
   logic [`WB_TAG_W-1:0]  exp_tag [NIDS];
   logic [`WB_ID_W-1:0]   wb_order [$];    // ids in writeback order.

   tb_clkgen #(.PERIOD(8)) u_clkgen (.clk(clk));

   wb_subsys_top u_dut
   (
      .clk (clk), .arst_n (arst_n),
      .alu_issue_valid (alu_issue_valid), .alu_issue_ready (alu_issue_ready),
      .alu_op (alu_op), .alu_a (alu_a), .alu_b (alu_b), .alu_tag (alu_tag), .alu_id (alu_id),
      .mul_issue_valid (mul_issue_valid), .mul_issue_ready (mul_issue_ready),
      .mul_a (mul_a), .mul_b (mul_b), .mul_tag (mul_tag), .mul_id (mul_id),
      .rob_wb_valid (rob_wb_valid), .rob_wb_ready (rob_wb_ready),
      .rob_wb_data (rob_wb_data), .rob_wb_tag (rob_wb_tag), .rob_wb_id (rob_wb_id)
   );

   task automatic stop_run();
      errors++;
      $display("STATUS: FAIL");
      $fatal(1);
   endtask

   task automatic value_error(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      $display("** Error at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
      stop_run();
   endtask

   task automatic report_error(input string what);
      $display("Error at %0t: %s.", $time, what);
      stop_run();
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // reference model.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   function automatic logic [`WB_DW-1:0] expected_result(input bit is_mul, input alu_op_e op,
      input logic [`WB_DW-1:0] a, input logic [`WB_DW-1:0] b);
      logic [2*`WB_DW-1:0] product;
      logic [`WB_DW-1:0]   res;
      int unsigned         sh;
      product = {{`WB_DW{1'b0}}, a} * {{`WB_DW{1'b0}}, b};   // low half is the result.
      sh      = b % `WB_DW;                                    // low 5 bits of b.
      case (op)
         ALU_ADD: res = a + b;
         ALU_SUB: res = a + ~b + 1'b1;
         ALU_AND: res = a & b;
         ALU_OR:  res = a | b;
         ALU_XOR: res = a ^ b;
         ALU_SLL: res = a << sh;
         ALU_SRL: res = a >> sh;
         default: res = '0;
      endcase
      return is_mul ? product[`WB_DW-1:0] : res;
   endfunction

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // stimulus tasks are always entered on a falling edge.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic take_id(output logic [`WB_ID_W-1:0] id);
      int unsigned waited;
      waited = 0;
      while (pending[next_id] && waited < T_ISSUE)
      begin
         waited++;
         @(negedge clk);
      end
      assert (!pending[next_id])
      else report_error("no free ROB id came back within the timeout");
      id          = next_id;
      next_id     = next_id + 1'b1;   // round robin over the id space.
      pending[id] = 1'b1;
      issued++;
   endtask

   task automatic issue_op(input bit is_mul, input alu_op_e op, input logic [`WB_DW-1:0] a,
      input logic [`WB_DW-1:0] b, output logic [`WB_ID_W-1:0] id,
      output int unsigned accepted_at);
      logic [`WB_TAG_W-1:0] tag;
      int unsigned          waited;
      string                unit_name;
      take_id(id);
      tag          = `WB_TAG_W'($random(seed));
      exp_data[id] = expected_result(is_mul, op, a, b);
      exp_tag[id]  = tag;
      if (is_mul)
      begin
         unit_name       = "multiplier";
         mul_a           = a;
         mul_b           = b;
         mul_tag         = tag;
         mul_id          = id;
         mul_issue_valid = 1'b1;
      end
      else
      begin
         unit_name       = "alu";
         alu_op          = op;
         alu_a           = a;
         alu_b           = b;
         alu_tag         = tag;
         alu_id          = id;
         alu_issue_valid = 1'b1;
      end
      waited = 0;
      @(posedge clk);
      while (!(is_mul ? mul_issue_ready : alu_issue_ready) && waited < T_ISSUE)
      begin
         waited++;
         @(posedge clk);
      end
      assert (is_mul ? mul_issue_ready : alu_issue_ready)
      else report_error({unit_name, " issue was never accepted"});
      accepted_at = cycle;   // edge of the handshake.
      @(negedge clk);
      mul_issue_valid = is_mul ? 1'b0 : mul_issue_valid;
      alu_issue_valid = is_mul ? alu_issue_valid : 1'b0;
   endtask

   task automatic random_stream(input bit is_mul, input int unsigned count);
      logic [`WB_ID_W-1:0] id;
      int unsigned         at;
      alu_op_e             op;
      for (int unsigned k = 0; k < count; k++)
      begin
         op = alu_op_e'(3'($unsigned($random(seed)) % 7));
         repeat ($unsigned($random(seed)) % 3) @(negedge clk);   // short idle gap.
         issue_op(is_mul, op, $random(seed), $random(seed), id, at);
      end
   endtask

   task automatic toggle_ready();
      int unsigned waited;
      waited = 0;
      while (!streams_done && waited < T_DRAIN)
      begin
         rob_wb_ready = ($unsigned($random(seed)) % 8) > 2;   // ready about 5 of 8.
         waited++;
         @(negedge clk);
      end
      assert (streams_done)
      else report_error("issue streams did not finish under back-pressure");
      rob_wb_ready = 1'b1;
   endtask

   task automatic drain_all();
      int unsigned waited;
      waited = 0;
      while (written != issued && waited < T_DRAIN)
      begin
         waited++;
         @(negedge clk);
      end
      assert (written == issued)
      else report_error($sformatf("only %0d of %0d issued ids were written back",
                                  written, issued));
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // scoreboard with one check per rob transfer.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always @(posedge clk)
   begin
      cycle <= cycle + 1;
      assert (u_dut.u_arb.u_wb_assertions.fail_count == 0)
      else report_error("a bound assertion on the arbiter failed");
      if (arst_n && rob_wb_valid && rob_wb_ready)
      begin
         assert (pending[rob_wb_id])
         else report_error($sformatf("id %0d written back but not outstanding", rob_wb_id));
         assert (rob_wb_data == exp_data[rob_wb_id])
         else value_error("rob_wb_data", rob_wb_data, exp_data[rob_wb_id]);
         assert (rob_wb_tag == exp_tag[rob_wb_id])
         else value_error("rob_wb_tag", rob_wb_tag, exp_tag[rob_wb_id]);
         pending[rob_wb_id] = 1'b0;   // a second copy would now fail.
         written++;
         wb_order.push_back(rob_wb_id);
      end
   end

   initial
   begin
      logic [`WB_ID_W-1:0] aid;
      logic [`WB_ID_W-1:0] mid;
      int unsigned         at;
      int unsigned         waited;
      seed            = 32'h05e8_ca63;
      cycle           = 0;
      issued          = 0;
      written         = 0;
      errors          = 0;
      next_id         = '0;
      streams_done    = 1'b0;
      arst_n          = 1'b0;
      alu_issue_valid = 1'b0;
      alu_op          = ALU_ADD;
      alu_a           = '0;
      alu_b           = '0;
      alu_tag         = '0;
      alu_id          = '0;
      mul_issue_valid = 1'b0;
      mul_a           = '0;
      mul_b           = '0;
      mul_tag         = '0;
      mul_id          = '0;
      rob_wb_ready    = 1'b1;
      repeat (5) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);

      // idle state after reset.
      assert (!rob_wb_valid) else value_error("rob_wb_valid", rob_wb_valid, 0);
      assert (alu_issue_ready) else value_error("alu_issue_ready", alu_issue_ready, 1);
      assert (mul_issue_ready) else value_error("mul_issue_ready", mul_issue_ready, 1);

      // every alu opcode back to back.
      for (int k = 0; k < 28; k++)
      begin
         issue_op(1'b0, alu_op_e'(3'(k % 7)), $random(seed), $random(seed), aid, at);
      end
      drain_all();

      // first multiplier result is timed with the rob always ready.
      issue_op(1'b1, ALU_ADD, $random(seed), $random(seed), mid, at);
      waited = 0;
      @(posedge clk);
      while (!rob_wb_valid && waited < T_ISSUE)
      begin
         waited++;
         @(posedge clk);
      end
      assert (rob_wb_valid) else report_error("first multiplier result never reached rob_wb");
      assert (cycle - at == `WB_DW + 1)
      else value_error("multiplier latency", cycle - at, `WB_DW + 1);
      assert (rob_wb_id == mid) else value_error("rob_wb_id", rob_wb_id, mid);
      @(negedge clk);
      random_stream(1'b1, 5);
      drain_all();

      // alu overtakes a waiting multiplier result.
      rob_wb_ready = 1'b0;
      issue_op(1'b1, ALU_ADD, $random(seed), $random(seed), mid, at);
      repeat (`WB_DW + 1) @(posedge clk);
      @(negedge clk);
      issue_op(1'b0, ALU_XOR, $random(seed), $random(seed), aid, at);
      wb_order.delete();
      rob_wb_ready = 1'b1;
      waited = 0;
      while (wb_order.size() < 2 && waited < T_ISSUE)
      begin
         waited++;
         @(negedge clk);
      end
      assert (wb_order.size() >= 2) else report_error("two transfers after the stall not seen");
      assert (wb_order[0] == aid) else value_error("first rob_wb_id", wb_order[0], aid);
      assert (wb_order[1] == mid) else value_error("second rob_wb_id", wb_order[1], mid);
      drain_all();

      // both units under random back-pressure.
      fork
         begin
            fork
               random_stream(1'b0, 40);
               random_stream(1'b1, 4);
            join
            streams_done = 1'b1;
         end
         toggle_ready();
      join
      drain_all();

      assert (u_dut.u_arb.u_wb_assertions.fail_count == 0)
      else report_error("a bound assertion on the arbiter failed");

      if (errors == 0)
      begin
         $display("STATUS: PASS");
         $finish;
      end
      else
      begin
         stop_run();
      end
   end

endmodule

/* flist.f */
+incdir+include
verilog/wb_pkg.sv
verilog/wb_arbiter.sv
verilog/alu_unit.sv
verilog/mul_unit.sv
verilog/wb_subsys_top.sv
verif/tb_clkgen.sv
verif/wb_assertions.sv
verif/wb_tb.sv
